// ==== hdl/pipe_settings.svh ====
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// instruction word and program counter width
`define ISA_WIDTH 32

// register file index width, 32 registers
`define REG_ADDR_WIDTH 5

// stage controls driven by the hazard unit: if, id, ex, mem, wb
`define STAGE_CNT 5

// last valid word address of the 64-word instruction memory
`define PC_MAX_VALUE 32'd252

// per-stage hazard control encoding width
`define CTRL_WIDTH 2

`endif

// ==== hdl/pipe_pkg.sv ====
`include "pipe_settings.svh"

package pipe_pkg;

    typedef enum logic [`CTRL_WIDTH-1:0] {
        NORMAL = 2'd0,                          // register loads its input
        HOLD   = 2'd1,                          // register keeps its value
        NO_OP  = 2'd2                           // register loads a bubble
    } hazard_ctrl_e;

    typedef enum logic [2:0] {
        NONE   = 3'd0,
        DATA   = 3'd1,                          // load-use or branch operand not ready
        UART   = 3'd2,                          // pc ran past instruction memory
        PAUSE  = 3'd3,                          // user pause, uart rewrite allowed
        KEYPAD = 3'd4                           // waiting for keypad entry
    } issue_e;

    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        EXECUTE   = 3'd1,
        HAZARD    = 3'd2,
        INTERRUPT = 3'd3,
        RESTART   = 3'd4                        // one cycle of pc_reset after uart rewrite
    } cpu_state_e;

    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        BEQ    = 6'h04,
        BNE    = 6'h05,
        ADDI   = 6'h08,
        LW     = 6'h23,
        SW     = 6'h2b,
        NOP_OP = 6'h3f
    } opcode_e;

    typedef struct packed {
        opcode_e                    opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [4:0]                 shamt;
        logic [5:0]                 funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e                    opcode;
        logic [`REG_ADDR_WIDTH-1:0] rs;
        logic [`REG_ADDR_WIDTH-1:0] rt;
        logic [15:0]                imm;
    } i_fmt_t;

    // one fetched word, two field layouts sharing the opcode
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

// ==== hdl/instr_decode.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module instr_decode (
    input  pipe_pkg::instr_u            instr,        // word currently in the id stage
    output logic [`REG_ADDR_WIDTH-1:0]  reg_1_idx,    // first source index
    output logic [`REG_ADDR_WIDTH-1:0]  reg_2_idx,    // second source index
    output logic [`REG_ADDR_WIDTH-1:0]  dest_idx,     // destination index
    output logic                        reg_1_valid,  // first source is really read
    output logic                        reg_2_valid,  // second source is really read
    output logic                        reg_write,    // writes a nonzero register
    output logic                        mem_read,     // load with a late result
    output logic                        branch        // compares operands in id
);
    import pipe_pkg::*;

    always_comb begin
        reg_1_idx   = instr.i.rs;                     // rs sits at the same bits in both views
        reg_2_idx   = instr.i.rt;
        dest_idx    = '0;
        reg_1_valid = 1'b0;
        reg_2_valid = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        branch      = 1'b0;
        case (instr.r.opcode)
            R_TYPE: begin
                reg_1_valid = 1'b1;
                reg_2_valid = 1'b1;
                dest_idx    = instr.r.rd;
                reg_write   = instr.r.rd != '0;       // $zero is never a producer
            end
            LW: begin
                reg_1_valid = 1'b1;                   // base address only
                dest_idx    = instr.i.rt;
                reg_write   = instr.i.rt != '0;
                mem_read    = 1'b1;
            end
            ADDI: begin
                reg_1_valid = 1'b1;
                dest_idx    = instr.i.rt;
                reg_write   = instr.i.rt != '0;
            end
            SW: begin
                reg_1_valid = 1'b1;                   // base plus store data
                reg_2_valid = 1'b1;
            end
            BEQ, BNE: begin
                reg_1_valid = 1'b1;
                reg_2_valid = 1'b1;
                branch      = 1'b1;
            end
            default: ;                                // NOP_OP and unknown opcodes read nothing
        endcase
    end

endmodule

// ==== hdl/stage_reg.sv ====
`timescale 1ns/100ps

module stage_reg #(
    parameter int WIDTH = 8                       // payload bits carried between stages
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe_pkg::hazard_ctrl_e ctrl,          // normal, hold or bubble
    input  logic [WIDTH-1:0]       d,             // payload from the earlier stage
    input  logic                   d_no_op,       // earlier stage already holds a bubble
    output logic [WIDTH-1:0]       q,
    output logic                   q_no_op        // this stage is a bubble
);
    import pipe_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            q       <= '0;                        // pipeline comes up empty
            q_no_op <= 1'b1;
        end else begin
            case (ctrl)
                NORMAL: begin
                    q       <= d;
                    q_no_op <= d_no_op;
                end
                NO_OP: begin
                    q       <= '0;                // bubble clears all write flags
                    q_no_op <= 1'b1;
                end
                default: ;                        // HOLD keeps the current contents
            endcase
        end
    end

endmodule

// ==== hdl/pc_unit.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pc_unit (
    input  logic                   clk,
    input  logic                   rst_n,
    input  pipe_pkg::hazard_ctrl_e if_ctrl,    // fetch stage control from hazard unit
    input  logic                   pc_reset,   // restart at word 0 after a rewrite
    output logic [`ISA_WIDTH-1:0]  pc,         // address of the word now fetched
    output logic [`ISA_WIDTH-1:0]  pc_next     // sequential successor
);
    import pipe_pkg::*;

    assign pc_next = pc + `ISA_WIDTH'd4;       // one word ahead, no branch target here

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (pc_reset) begin
            pc <= '0;                          // wins over any stage control
        end else if (if_ctrl == NORMAL) begin
            pc <= pc_next;
        end
        // hold and bubble both freeze the pc so the word is fetched again
    end

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module hazard_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        uart_complete,        // rewrite finished
    input  logic                        reg_1_valid,          // id reads first source
    input  logic                        reg_2_valid,          // id reads second source
    input  logic                        branch_instruction,   // id holds a beq or bne
    input  logic                        ex_mem_read_enable,   // ex holds a load
    input  logic                        ex_reg_write_enable,
    input  logic                        ex_no_op,             // ex is a bubble
    input  logic                        mem_reg_write_enable,
    input  logic                        mem_no_op,            // mem is a bubble
    input  logic [`REG_ADDR_WIDTH-1:0]  id_reg_1_idx,
    input  logic [`REG_ADDR_WIDTH-1:0]  id_reg_2_idx,
    input  logic [`REG_ADDR_WIDTH-1:0]  ex_reg_dest_idx,
    input  logic [`REG_ADDR_WIDTH-1:0]  mem_reg_dest_idx,
    input  logic [`ISA_WIDTH-1:0]       pc_next,              // sequential fetch address
    input  logic                        input_enable,         // data side wants keypad data
    input  logic                        input_complete,       // user pressed enter
    input  logic                        cpu_pause,            // user pause level
    output logic                        uart_disable,         // low lets the uart rewrite memory
    output logic                        pc_reset,             // restart fetch at 0
    output pipe_pkg::hazard_ctrl_e      if_hazard_control,
    output pipe_pkg::hazard_ctrl_e      id_hazard_control,
    output pipe_pkg::hazard_ctrl_e      ex_hazard_control,
    output pipe_pkg::hazard_ctrl_e      mem_hazard_control,
    output pipe_pkg::hazard_ctrl_e      wb_hazard_control,
    output pipe_pkg::issue_e            issue_type            // shown on the display
);
    import pipe_pkg::*;

    localparam int IF_S  = 0;                                  // stage slots in ctrl_q
    localparam int ID_S  = 1;
    localparam int EX_S  = 2;
    localparam int MEM_S = 3;
    localparam int WB_S  = 4;

    hazard_ctrl_e ctrl_q [`STAGE_CNT];                         // registered stage controls
    cpu_state_e   state;
    logic         ex_conflict;
    logic         mem_conflict;
    logic         data_hazard;
    logic         pc_overflow;

    // a live producer in ex or mem writes a register that id reads
    assign ex_conflict  = ex_reg_write_enable & ~ex_no_op &
                          ((reg_1_valid & (id_reg_1_idx == ex_reg_dest_idx)) |
                           (reg_2_valid & (id_reg_2_idx == ex_reg_dest_idx)));
    assign mem_conflict = mem_reg_write_enable & ~mem_no_op &
                          ((reg_1_valid & (id_reg_1_idx == mem_reg_dest_idx)) |
                           (reg_2_valid & (id_reg_2_idx == mem_reg_dest_idx)));

    assign data_hazard = (branch_instruction & (ex_conflict | mem_conflict)) |  // branch resolves in id
                         (ex_mem_read_enable & ex_conflict);                    // load-use
    assign pc_overflow = pc_next > `PC_MAX_VALUE;                               // next word not in imem

    assign if_hazard_control  = ctrl_q[IF_S];
    assign id_hazard_control  = ctrl_q[ID_S];
    assign ex_hazard_control  = ctrl_q[EX_S];
    assign mem_hazard_control = ctrl_q[MEM_S];
    assign wb_hazard_control  = ctrl_q[WB_S];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= IDLE;
            issue_type   <= NONE;
            uart_disable <= 1'b1;
            pc_reset     <= 1'b0;
            for (int i = 0; i < `STAGE_CNT; i++) begin
                ctrl_q[i] <= NORMAL;
            end
        end else begin
            case (state)
                EXECUTE: begin
                    if (data_hazard) begin                     // stall id, drain ex
                        issue_type   <= DATA;
                        state        <= HAZARD;
                        ctrl_q[IF_S] <= HOLD;
                        ctrl_q[ID_S] <= HOLD;
                        ctrl_q[EX_S] <= NO_OP;
                    end else if (cpu_pause) begin              // user may rewrite while paused
                        issue_type   <= PAUSE;
                        state        <= HAZARD;
                        uart_disable <= 1'b0;
                        ctrl_q[IF_S] <= NO_OP;
                    end else if (pc_overflow) begin            // resumes by itself after rewrite
                        issue_type   <= UART;
                        state        <= HAZARD;
                        uart_disable <= 1'b0;
                        ctrl_q[IF_S] <= NO_OP;
                    end else if (input_enable) begin           // freeze the whole pipe
                        issue_type <= KEYPAD;
                        state      <= INTERRUPT;
                        for (int i = 0; i < `STAGE_CNT; i++) begin
                            ctrl_q[i] <= NO_OP;
                        end
                    end
                end
                HAZARD: begin
                    case (issue_type)
                        DATA: begin
                            if (!data_hazard) begin            // producer moved far enough on
                                issue_type   <= NONE;
                                state        <= EXECUTE;
                                ctrl_q[IF_S] <= NORMAL;
                                ctrl_q[ID_S] <= NORMAL;
                                ctrl_q[EX_S] <= NORMAL;
                            end
                        end
                        UART: begin
                            if (cpu_pause) begin
                                issue_type <= PAUSE;           // user now owns the resume
                            end else if (uart_complete) begin
                                issue_type   <= NONE;
                                state        <= RESTART;
                                uart_disable <= 1'b1;
                                pc_reset     <= 1'b1;
                                ctrl_q[IF_S] <= HOLD;          // pc goes to 0 this cycle
                            end
                        end
                        PAUSE: begin
                            if (!cpu_pause && uart_complete) begin
                                issue_type   <= NONE;
                                state        <= EXECUTE;
                                uart_disable <= 1'b1;
                                ctrl_q[IF_S] <= NORMAL;        // carry on from the held pc
                            end
                        end
                        default: state <= EXECUTE;             // no issue to wait for
                    endcase
                end
                INTERRUPT: begin
                    if (input_complete) begin
                        issue_type <= NONE;
                        state      <= EXECUTE;
                        for (int i = 0; i < `STAGE_CNT; i++) begin
                            ctrl_q[i] <= NORMAL;
                        end
                    end
                end
                RESTART: begin
                    pc_reset     <= 1'b0;                      // single pulse
                    ctrl_q[IF_S] <= NORMAL;
                    state        <= EXECUTE;
                end
                default: state <= EXECUTE;                     // IDLE lasts one cycle
            endcase
        end
    end

endmodule

// ==== hdl/pipe_ctrl_top.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_ctrl_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  pipe_pkg::instr_u           instr,           // word fetched at pc
    input  logic                       uart_complete,
    input  logic                       cpu_pause,
    input  logic                       input_enable,
    input  logic                       input_complete,
    output logic [`ISA_WIDTH-1:0]      pc,
    output logic                       uart_disable,
    output pipe_pkg::issue_e           issue_type,
    output pipe_pkg::hazard_ctrl_e     if_hazard_control,
    output pipe_pkg::hazard_ctrl_e     id_hazard_control,
    output pipe_pkg::hazard_ctrl_e     ex_hazard_control,
    output pipe_pkg::hazard_ctrl_e     mem_hazard_control,
    output pipe_pkg::hazard_ctrl_e     wb_hazard_control,
    output logic [`REG_ADDR_WIDTH-1:0] wb_dest_idx,     // register written back
    output logic                       wb_reg_write
);
    import pipe_pkg::*;

    localparam int SW = `REG_ADDR_WIDTH + 2;             // {dest, reg_write, mem_read}

    logic [`REG_ADDR_WIDTH-1:0] reg_1_idx, reg_2_idx, dest_idx;
    logic                       reg_1_valid, reg_2_valid;
    logic                       reg_write, mem_read, branch;
    logic [`ISA_WIDTH-1:0]      pc_next;
    logic                       pc_reset;
    logic                       id_no_op;
    logic [SW-1:0]              ex_q, mem_q, wb_q;
    logic                       ex_no_op, mem_no_op, wb_no_op;

    assign id_no_op     = if_hazard_control == NO_OP;    // fetch is feeding bubbles
    assign wb_dest_idx  = wb_q[SW-1:2];
    assign wb_reg_write = wb_q[1] & ~wb_no_op;

    instr_decode decode_i (
        .instr(instr), .reg_1_idx(reg_1_idx), .reg_2_idx(reg_2_idx), .dest_idx(dest_idx),
        .reg_1_valid(reg_1_valid), .reg_2_valid(reg_2_valid), .reg_write(reg_write),
        .mem_read(mem_read), .branch(branch)
    );

    // each register obeys the control of the stage it feeds
    stage_reg #(.WIDTH(SW)) id_ex_i (
        .clk(clk), .rst_n(rst_n), .ctrl(ex_hazard_control),
        .d({dest_idx, reg_write, mem_read}), .d_no_op(id_no_op), .q(ex_q), .q_no_op(ex_no_op)
    );

    stage_reg #(.WIDTH(SW)) ex_mem_i (
        .clk(clk), .rst_n(rst_n), .ctrl(mem_hazard_control),
        .d(ex_q), .d_no_op(ex_no_op), .q(mem_q), .q_no_op(mem_no_op)
    );

    stage_reg #(.WIDTH(SW)) mem_wb_i (
        .clk(clk), .rst_n(rst_n), .ctrl(wb_hazard_control),
        .d(mem_q), .d_no_op(mem_no_op), .q(wb_q), .q_no_op(wb_no_op)
    );

    pc_unit pc_i (
        .clk(clk), .rst_n(rst_n), .if_ctrl(if_hazard_control), .pc_reset(pc_reset),
        .pc(pc), .pc_next(pc_next)
    );

    hazard_unit hazard_i (
        .clk(clk), .rst_n(rst_n), .uart_complete(uart_complete),
        .reg_1_valid(reg_1_valid), .reg_2_valid(reg_2_valid), .branch_instruction(branch),
        .ex_mem_read_enable(ex_q[0]), .ex_reg_write_enable(ex_q[1]), .ex_no_op(ex_no_op),
        .mem_reg_write_enable(mem_q[1]), .mem_no_op(mem_no_op),
        .id_reg_1_idx(reg_1_idx), .id_reg_2_idx(reg_2_idx),
        .ex_reg_dest_idx(ex_q[SW-1:2]), .mem_reg_dest_idx(mem_q[SW-1:2]),
        .pc_next(pc_next), .input_enable(input_enable), .input_complete(input_complete),
        .cpu_pause(cpu_pause), .uart_disable(uart_disable), .pc_reset(pc_reset),
        .if_hazard_control(if_hazard_control), .id_hazard_control(id_hazard_control),
        .ex_hazard_control(ex_hazard_control), .mem_hazard_control(mem_hazard_control),
        .wb_hazard_control(wb_hazard_control), .issue_type(issue_type)
    );

endmodule

// ==== dv/tb_clk_gen.sv ====
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk,                         // 8 ns period
    output logic rst_n                        // low for the first 16 rising edges
);
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        #1 rst_n = 1'b1;                      // released off the edge like other inputs
    end

endmodule

// ==== dv/pipe_ctrl_assert.sv ====
`timescale 1ns/100ps

module pipe_ctrl_assert (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   uart_disable,
    input logic                   pc_reset,
    input pipe_pkg::hazard_ctrl_e if_hazard_control,
    input pipe_pkg::hazard_ctrl_e id_hazard_control,
    input pipe_pkg::hazard_ctrl_e ex_hazard_control,
    input pipe_pkg::hazard_ctrl_e mem_hazard_control,
    input pipe_pkg::hazard_ctrl_e wb_hazard_control,
    input pipe_pkg::issue_e       issue_type
);
    import pipe_pkg::*;

    // keypad wait freezes the whole pipe
    keypad_freeze: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_type == KEYPAD) |-> (if_hazard_control == NO_OP && id_hazard_control == NO_OP &&
                                    ex_hazard_control == NO_OP && mem_hazard_control == NO_OP &&
                                    wb_hazard_control == NO_OP))
        else $error("keypad wait with a stage not on bubble");

    // restart is a single pulse
    pc_reset_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pc_reset |=> !pc_reset)
        else $error("pc_reset held for more than one cycle");

    // uart may only write while the pipe is parked for it
    uart_locked: assert property (@(posedge clk) disable iff (!rst_n)
        (issue_type == NONE || issue_type == DATA) |-> uart_disable)
        else $error("uart enabled outside a uart or pause issue");

endmodule

bind hazard_unit pipe_ctrl_assert assert_i (
    .clk(clk), .rst_n(rst_n), .uart_disable(uart_disable), .pc_reset(pc_reset),
    .if_hazard_control(if_hazard_control), .id_hazard_control(id_hazard_control),
    .ex_hazard_control(ex_hazard_control), .mem_hazard_control(mem_hazard_control),
    .wb_hazard_control(wb_hazard_control), .issue_type(issue_type)
);

// ==== dv/pipe_ctrl_tb.sv ====
`timescale 1ns/100ps
`include "pipe_settings.svh"

module pipe_ctrl_tb;
    import pipe_pkg::*;

    localparam int MAX_ROWS = 128;
    localparam logic [3:0] IN_NONE  = 4'b0000;          // {cpu_pause, uart_complete,
    localparam logic [3:0] IN_PAUSE = 4'b1000;          //  input_enable, input_complete}
    localparam logic [3:0] IN_UC    = 4'b0100;
    localparam logic [3:0] IN_IE    = 4'b0010;
    localparam logic [3:0] IN_IC    = 4'b0001;
    localparam logic [6:0] BUBBLE   = 7'b100_0000;      // {bubble, write, dest}

    logic                       clk, rst_n;
    instr_u                     instr;
    logic                       uart_complete, cpu_pause, input_enable, input_complete;
    logic [`ISA_WIDTH-1:0]      pc;
    logic                       uart_disable;
    issue_e                     issue_type;
    hazard_ctrl_e               if_ctrl, id_ctrl, ex_ctrl, mem_ctrl, wb_ctrl;
    logic [`REG_ADDR_WIDTH-1:0] wb_dest_idx;
    logic                       wb_reg_write;

    instr_u                row_instr [MAX_ROWS];        // one row per clock
    logic [3:0]            row_in    [MAX_ROWS];
    issue_e                row_issue [MAX_ROWS];        // expected after the edge
    hazard_ctrl_e          row_if    [MAX_ROWS];
    logic [`ISA_WIDTH-1:0] row_pc    [MAX_ROWS];
    int                    n_rows;
    logic [`ISA_WIDTH-1:0] pc_model;                    // pc expected after the last row
    logic [6:0]            m_ex, m_mem, m_wb;           // expected stage contents
    logic [31:0]           rng;
    int                    cycles;
    int                    limit;

    tb_clk_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

    pipe_ctrl_top dut_i (
        .clk(clk), .rst_n(rst_n), .instr(instr), .uart_complete(uart_complete),
        .cpu_pause(cpu_pause), .input_enable(input_enable), .input_complete(input_complete),
        .pc(pc), .uart_disable(uart_disable), .issue_type(issue_type),
        .if_hazard_control(if_ctrl), .id_hazard_control(id_ctrl), .ex_hazard_control(ex_ctrl),
        .mem_hazard_control(mem_ctrl), .wb_hazard_control(wb_ctrl),
        .wb_dest_idx(wb_dest_idx), .wb_reg_write(wb_reg_write)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic instr_u make_r(input logic [4:0] rs, input logic [4:0] rt,
                                      input logic [4:0] rd);
        instr_u w;
        w.r.opcode = R_TYPE;
        w.r.rs     = rs;
        w.r.rt     = rt;
        w.r.rd     = rd;
        w.r.shamt  = 5'd0;
        w.r.funct  = 6'h20;                             // add
        return w;
    endfunction

    function automatic instr_u make_i(input opcode_e op, input logic [4:0] rs,
                                      input logic [4:0] rt);
        instr_u w;
        w.i.opcode = op;
        w.i.rs     = rs;
        w.i.rt     = rt;
        w.i.imm    = 16'h0010;
        return w;
    endfunction

    // register a word writes back, as {write, dest}
    function automatic logic [5:0] writer_of(input instr_u w);
        logic [4:0] d;
        case (w.i.opcode)
            R_TYPE:   d = w.r.rd;
            LW, ADDI: d = w.i.rt;
            default:  d = 5'd0;
        endcase
        return {d != 5'd0, d};                          // $zero is never written
    endfunction

    // expected pipe contents move on under the controls shown after the previous row
    task automatic step_model(input instr_u w, input issue_e iss, input hazard_ctrl_e ifc);
        if (iss == KEYPAD) begin
            m_wb  = BUBBLE;
            m_mem = BUBBLE;
        end else begin
            m_wb  = m_mem;
            m_mem = m_ex;
        end
        if (iss == KEYPAD || iss == DATA) begin
            m_ex = BUBBLE;
        end else begin
            m_ex = {ifc == NO_OP, writer_of(w)};        // word behind a fetch bubble is dead
        end
    endtask

    task automatic next_filler(output instr_u w);
        rng = xorshift(rng);
        w = rng;
        w.i.opcode = NOP_OP;                            // nop reads and writes nothing
    endtask

    task automatic add_row(input instr_u w, input logic [3:0] in, input issue_e iss,
                           input hazard_ctrl_e ifc);
        if (n_rows > 0 && row_issue[n_rows-1] == NONE && row_if[n_rows-1] == HOLD) begin
            pc_model = '0;                              // restart cycle pulses pc_reset
        end else if (n_rows == 0 || row_if[n_rows-1] == NORMAL) begin
            pc_model = pc_model + 32'd4;
        end
        row_instr[n_rows] = w;
        row_in[n_rows]    = in;
        row_issue[n_rows] = iss;
        row_if[n_rows]    = ifc;
        row_pc[n_rows]    = pc_model;
        n_rows++;
    endtask

    task automatic add_filler(input int n);
        instr_u w;
        for (int k = 0; k < n; k++) begin
            next_filler(w);
            add_row(w, IN_NONE, NONE, NORMAL);
        end
    endtask

    task automatic build_table();
        instr_u w;
        add_filler(3);
        add_row(make_i(LW, 5'd1, 5'd5), IN_NONE, NONE, NORMAL);     // load-use on r5
        add_row(make_r(5'd5, 5'd2, 5'd6), IN_NONE, DATA, HOLD);
        add_row(make_r(5'd5, 5'd2, 5'd6), IN_NONE, NONE, NORMAL);
        add_filler(2);
        add_row(make_i(ADDI, 5'd0, 5'd7), IN_NONE, NONE, NORMAL);   // branch right after writer
        add_row(make_i(BEQ, 5'd7, 5'd0), IN_NONE, DATA, HOLD);
        add_row(make_i(BEQ, 5'd7, 5'd0), IN_NONE, DATA, HOLD);     // writer now in mem
        add_row(make_i(BEQ, 5'd7, 5'd0), IN_NONE, NONE, NORMAL);
        add_filler(2);
        add_row(make_i(ADDI, 5'd0, 5'd8), IN_NONE, NONE, NORMAL);   // branch two behind writer
        add_filler(1);
        add_row(make_i(BNE, 5'd8, 5'd0), IN_NONE, DATA, HOLD);
        add_row(make_i(BNE, 5'd8, 5'd0), IN_NONE, NONE, NORMAL);
        add_filler(2);
        add_row(make_i(LW, 5'd0, 5'd9), IN_NONE, NONE, NORMAL);     // rt of addi is no source
        add_row(make_i(ADDI, 5'd0, 5'd9), IN_NONE, NONE, NORMAL);
        add_filler(1);
        add_row(make_i(LW, 5'd1, 5'd0), IN_NONE, NONE, NORMAL);     // load into $zero
        add_row(make_r(5'd0, 5'd0, 5'd3), IN_NONE, NONE, NORMAL);
        add_filler(2);
        next_filler(w);
        add_row(w, IN_PAUSE, PAUSE, NO_OP);
        add_row(make_i(LW, 5'd0, 5'd10), IN_PAUSE, PAUSE, NO_OP);  // enters ex as a bubble
        add_row(make_i(LW, 5'd0, 5'd10), IN_NONE, PAUSE, NO_OP);   // needs uart_complete too
        add_row(make_i(LW, 5'd0, 5'd10), IN_UC, NONE, NORMAL);
        add_row(make_r(5'd10, 5'd0, 5'd11), IN_NONE, NONE, NORMAL); // bubble producer stalls nothing
        add_filler(2);
        next_filler(w);
        add_row(w, IN_IE, KEYPAD, NO_OP);
        next_filler(w);
        add_row(w, IN_IE, KEYPAD, NO_OP);
        next_filler(w);
        add_row(w, IN_IC, NONE, NORMAL);
        add_filler(1);
        while (pc_model != `PC_MAX_VALUE) begin        // run up to the last imem word
            add_filler(1);
        end
        next_filler(w);
        add_row(w, IN_NONE, UART, NO_OP);               // pc_next leaves imem
        add_row(w, IN_NONE, UART, NO_OP);
        add_row(w, IN_PAUSE, PAUSE, NO_OP);             // pause takes over the uart wait
        add_row(w, IN_UC, NONE, NORMAL);
        add_row(w, IN_NONE, UART, NO_OP);               // still past the top
        add_row(w, IN_UC, NONE, HOLD);                  // restart cycle
        add_row(w, IN_NONE, NONE, NORMAL);
        add_filler(2);
    endtask

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_issue(input issue_e got, input issue_e exp, input int row);
        if (got !== exp) begin
            fail_now($sformatf("Error at %0t: row %0d issue_type %s, expected %s",
                               $time, row, got.name(), exp.name()));
        end
    endtask

    task automatic check_ctrl(input hazard_ctrl_e got, input hazard_ctrl_e exp,
                              input string stage, input int row);
        if (got !== exp) begin
            fail_now($sformatf("Error at %0t: row %0d %s control %s, expected %s",
                               $time, row, stage, got.name(), exp.name()));
        end
    endtask

    task automatic check_pc(input logic [`ISA_WIDTH-1:0] got,
                            input logic [`ISA_WIDTH-1:0] exp, input int row);
        if (got !== exp) begin
            fail_now($sformatf("Error at %0t: row %0d pc %0d, expected %0d",
                               $time, row, got, exp));
        end
    endtask

    task automatic check_idx(input logic [`REG_ADDR_WIDTH-1:0] got,
                             input logic [`REG_ADDR_WIDTH-1:0] exp, input int row);
        if (got !== exp) begin
            fail_now($sformatf("Error at %0t: row %0d wb_dest_idx %0d, expected %0d",
                               $time, row, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what,
                              input int row);
        if (got !== exp) begin
            fail_now($sformatf("Error at %0t: row %0d %s %b, expected %b",
                               $time, row, what, got, exp));
        end
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycles = cycles + 1;
            if (cycles > limit) begin
                fail_now($sformatf("Timeout: run still going after %0d cycles", limit));
            end
        end
    end

    initial begin
        instr          = '0;
        uart_complete  = 1'b0;
        cpu_pause      = 1'b0;
        input_enable   = 1'b0;
        input_complete = 1'b0;
        cycles         = 0;
        n_rows         = 0;
        pc_model       = '0;
        m_ex           = BUBBLE;                        // pipe comes up empty
        m_mem          = BUBBLE;
        m_wb           = BUBBLE;
        rng            = 32'd31573;
        build_table();
        limit = n_rows + 64;
        wait (rst_n === 1'b1);                          // lands 1 ns after an edge
        for (int r = 0; r < n_rows; r++) begin
            instr = row_instr[r];
            {cpu_pause, uart_complete, input_enable, input_complete} = row_in[r];
            if (r == 0) begin
                step_model(row_instr[r], NONE, NORMAL); // controls leave reset normal
            end else begin
                step_model(row_instr[r], row_issue[r-1], row_if[r-1]);
            end
            @(posedge clk);
            #1;
            check_issue(issue_type, row_issue[r], r);
            check_ctrl(if_ctrl, row_if[r], "if", r);
            check_pc(pc, row_pc[r], r);
            check_flag(uart_disable, !(row_issue[r] == UART || row_issue[r] == PAUSE),
                       "uart_disable", r);
            check_flag(wb_reg_write, m_wb[5] & ~m_wb[6], "wb_reg_write", r);
            if (m_wb[5] && !m_wb[6]) begin              // index only matters on a live write
                check_idx(wb_dest_idx, m_wb[4:0], r);
            end
            if (row_issue[r] == DATA) begin             // id stalls while ex takes a bubble
                check_ctrl(id_ctrl, HOLD, "id", r);
                check_ctrl(ex_ctrl, NO_OP, "ex", r);
            end
            if (row_issue[r] == NONE) begin
                check_ctrl(id_ctrl, NORMAL, "id", r);
                check_ctrl(ex_ctrl, NORMAL, "ex", r);
                check_ctrl(mem_ctrl, NORMAL, "mem", r);
                check_ctrl(wb_ctrl, NORMAL, "wb", r);
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hdl
hdl/pipe_pkg.sv
hdl/instr_decode.sv
hdl/stage_reg.sv
hdl/pc_unit.sv
hdl/hazard_unit.sv
hdl/pipe_ctrl_top.sv
dv/tb_clk_gen.sv
dv/pipe_ctrl_assert.sv
dv/pipe_ctrl_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the pipeline control testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sources.f \
    --top-module pipe_ctrl_tb \
    -Mdir obj_dir

# exit status of the model is the test result
./obj_dir/Vpipe_ctrl_tb
